// ==== autd_drive.f ====
rtl/autd_pkg.sv
rtl/cpu_bus_if.sv
rtl/modulation_unit.sv
rtl/drive_memory.sv
rtl/duty_combiner.sv
rtl/autd_drive_top.sv
verification/autd_drive_properties.sv
verification/tb_autd_drive.sv

// ==== Makefile ====
TOP  := tb_autd_drive
SIM  := obj_dir/V$(TOP)
SRCS := $(shell grep -v '^+' autd_drive.f)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): autd_drive.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f autd_drive.f \
		--top-module $(TOP) -Mdir obj_dir

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

// ==== verification/tb_autd_drive.sv ====
// ====================
// Directed testbench for the drive-data path. Writes drive and
// modulation data over the CPU bus and checks the duty and phase
// stream against values worked out from the written data.
// ====================

`timescale 1ns/1ps

module tb_autd_drive;

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 10;
  localparam int N            = autd_pkg::NUM_TRANS;
  localparam int WRITE_CYCLES = 5;
  localparam int UNION_SCANS  = 10;
  localparam int UNION_DIV    = 1000;
  localparam int STEP_DIV     = 600;
  localparam int STEP_WINDOW  = 4 * STEP_DIV;

  // Cycle counts of the tests, which bound the watchdog
  localparam int RESET_TEST  = RESET_CYCLES + 2 + 2 * N;
  localparam int CONST_TEST  = WRITE_CYCLES * (N + 1) + 2 * N;
  localparam int UNION_TEST  = WRITE_CYCLES * 5 + (UNION_SCANS + 1) * N;
  localparam int STEP_TEST   = WRITE_CYCLES * (N + 4) + STEP_WINDOW;
  localparam int IGNORE_TEST = WRITE_CYCLES * 12 + 2 * N;
  localparam int ALL_TESTS   = RESET_TEST + CONST_TEST + UNION_TEST + STEP_TEST + IGNORE_TEST;

  logic        CPU_CKIO;
  logic        rst;
  logic [16:0] cpu_addr;
  logic [15:0] cpu_data;
  logic        cpu_cs1_n;
  logic        cpu_we0_n;
  logic        out_valid;
  logic [7:0]  out_idx;
  logic [7:0]  out_duty;
  logic [7:0]  out_phase;

  logic [7:0]  exp_int   [N];
  logic [7:0]  exp_phase [N];
  logic [7:0]  cur_sample;
  logic [31:0] rng_state;

  autd_drive_top u_dut (
    .CPU_CKIO  (CPU_CKIO),
    .rst       (rst),
    .cpu_addr  (cpu_addr),
    .cpu_data  (cpu_data),
    .cpu_cs1_n (cpu_cs1_n),
    .cpu_we0_n (cpu_we0_n),
    .out_valid (out_valid),
    .out_idx   (out_idx),
    .out_duty  (out_duty),
    .out_phase (out_phase)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Pin address bit 0 is the byte lane
  function automatic logic [16:0] pin_addr(input logic [1:0] sel, input logic [13:0] word);
    return {sel, word, 1'b0};
  endfunction

  function automatic logic [7:0] scaled_duty(input logic [7:0] amp, input logic [7:0] sample);
    logic [15:0] prod;
    prod = 16'(amp) * 16'(sample);
    return prod[15:8];
  endfunction

  task automatic next_cycle();
    @(posedge CPU_CKIO);
    #DRIVE_DELAY;
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check(input string name, input logic [15:0] actual,
                       input logic [15:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  // Chip select first, write enable low for two edges, then release
  task automatic bus_write(input logic [16:0] addr, input logic [15:0] data);
    cpu_addr  = addr;
    cpu_data  = data;
    cpu_cs1_n = 1'b0;
    next_cycle();
    cpu_we0_n = 1'b0;
    repeat (2) next_cycle();
    cpu_we0_n = 1'b1;
    next_cycle();
    cpu_cs1_n = 1'b1;
    next_cycle();
  endtask

  task automatic set_freq_div(input logic [31:0] div);
    bus_write(pin_addr(autd_pkg::BRAM_SELECT_CONTROLLER, autd_pkg::ADDR_MOD_FREQ_DIV_1),
              div[31:16]);
    bus_write(pin_addr(autd_pkg::BRAM_SELECT_CONTROLLER, autd_pkg::ADDR_MOD_FREQ_DIV_0),
              div[15:0]);
  endtask

  task automatic set_mod_cycle(input logic [15:0] last);
    bus_write(pin_addr(autd_pkg::BRAM_SELECT_CONTROLLER, autd_pkg::ADDR_MOD_CYCLE), last);
  endtask

  task automatic load_drive(input logic full);
    for (int i = 0; i < N; i++) begin
      rng_state    = xorshift32(rng_state);
      exp_int[i]   = full ? 8'hff : rng_state[15:8];
      exp_phase[i] = rng_state[7:0];
      bus_write(pin_addr(autd_pkg::BRAM_SELECT_NORMAL, 14'(i)), {exp_int[i], exp_phase[i]});
    end
  endtask

  task automatic wait_for_index(input logic [7:0] idx);
    next_cycle();
    while (!(out_valid === 1'b1 && out_idx == idx)) begin
      next_cycle();
    end
  endtask

  // One full scan against the model and the current sample
  task automatic check_scan();
    wait_for_index(8'd0);
    for (int i = 0; i < N; i++) begin
      if (i > 0) begin
        next_cycle();
      end
      check("out_valid", out_valid, 1'b1);
      check("out_idx", out_idx, 16'(i));
      check("out_phase", out_phase, exp_phase[i]);
      check("out_duty", out_duty, scaled_duty(exp_int[i], cur_sample));
    end
  endtask

  task automatic reset_walk();
    logic [7:0] idx;
    repeat (RESET_CYCLES) begin
      next_cycle();
      check("out_valid", out_valid, 1'b0);
    end
    rst = 1'b0;
    next_cycle();
    check("out_valid", out_valid, 1'b0);  // Scan strobe is still one stage away
    next_cycle();
    check("out_valid", out_valid, 1'b1);
    check("out_idx", out_idx, 8'd0);
    idx = 8'd0;
    repeat (2 * N) begin
      next_cycle();
      idx = (idx == 8'(N - 1)) ? 8'd0 : idx + 8'd1;
      check("out_valid", out_valid, 1'b1);
      check("out_idx", out_idx, idx);
    end
  endtask

  // Mod cycle is still 0 from reset, so sample 0 is held
  task automatic constant_modulation();
    rng_state  = xorshift32(rng_state);
    cur_sample = rng_state[7:0];
    bus_write(pin_addr(autd_pkg::BRAM_SELECT_MOD, 14'd0), {rng_state[15:8], cur_sample});
    load_drive(1'b0);
    check_scan();
  endtask

  task automatic union_decode();
    logic [15:0] word;
    logic [7:0]  p_even;
    logic [7:0]  p_odd;
    logic        seen_even;
    logic        seen_odd;
    rng_state = xorshift32(rng_state);
    word      = (rng_state[15:0] | 16'h8000) & 16'hff3f;  // High intensity and distinct products
    p_even    = scaled_duty(word[15:8], word[7:0]);
    p_odd     = scaled_duty(word[15:8], word[15:8]);
    seen_even = 1'b0;
    seen_odd  = 1'b0;
    bus_write(pin_addr(autd_pkg::BRAM_SELECT_MOD, 14'd0), word);
    bus_write(pin_addr(autd_pkg::BRAM_SELECT_NORMAL, 14'd5), word);
    exp_int[5]   = word[15:8];
    exp_phase[5] = word[7:0];
    set_freq_div(UNION_DIV);
    set_mod_cycle(16'd1);
    repeat (UNION_SCANS) begin
      wait_for_index(8'd5);
      check("out_phase", out_phase, word[7:0]);
      if (out_duty !== p_even && out_duty !== p_odd) begin
        fail_run($sformatf("FAIL out_duty: got 0x%0h, expected 0x%0h or 0x%0h",
                           out_duty, p_even, p_odd));
      end
      if (out_duty == p_even) begin
        seen_even = 1'b1;
      end
      if (out_duty == p_odd) begin
        seen_odd = 1'b1;
      end
    end
    if (!(seen_even && seen_odd)) begin
      fail_run("Transducer 5 duty never took both the even and the odd sample");
    end
  endtask

  task automatic modulation_stepping();
    logic [7:0] s0;
    logic [7:0] s1;
    logic [7:0] d0;
    logic [7:0] d1;
    logic [7:0] prev;
    int         run;
    int         changes;
    rng_state = xorshift32(rng_state);
    s0 = rng_state[7:0];
    s1 = ~s0;
    d0 = scaled_duty(8'hff, s0);
    d1 = scaled_duty(8'hff, s1);
    load_drive(1'b1);
    bus_write(pin_addr(autd_pkg::BRAM_SELECT_MOD, 14'd0), {s1, s0});
    set_freq_div(STEP_DIV);
    set_mod_cycle(16'd1);
    prev    = out_duty;
    run     = 1;
    changes = 0;
    repeat (STEP_WINDOW) begin
      next_cycle();
      check("out_valid", out_valid, 1'b1);
      if (out_duty !== d0 && out_duty !== d1) begin
        fail_run($sformatf("FAIL out_duty: got 0x%0h, expected 0x%0h or 0x%0h",
                           out_duty, d0, d1));
      end
      if (out_duty == prev) begin
        run++;
      end else begin
        // The run before the first change began outside the window
        if (changes > 0 && run < STEP_DIV - 1) begin
          fail_run($sformatf("Duty 0x%0h was held for only %0d outputs", prev, run));
        end
        changes++;
        prev = out_duty;
        run  = 1;
      end
    end
    if (changes < 2) begin
      fail_run("Modulation did not step between the two samples");
    end
  endtask

  task automatic ignored_writes();
    logic [13:0] stm_addr [4];
    logic [13:0] bad_addr [5];
    stm_addr = '{14'd5, autd_pkg::ADDR_MOD_CYCLE, autd_pkg::ADDR_MOD_FREQ_DIV_0, 14'd200};
    bad_addr = '{14'(N), 14'(N + 1), 14'd255, 14'd261, 14'h3fff};
    rng_state  = xorshift32(rng_state);
    cur_sample = rng_state[7:0];
    bus_write(pin_addr(autd_pkg::BRAM_SELECT_MOD, 14'd0), {rng_state[15:8], cur_sample});
    set_mod_cycle(16'd0);
    for (int i = 0; i < 4; i++) begin
      rng_state = xorshift32(rng_state);
      bus_write(pin_addr(autd_pkg::BRAM_SELECT_STM, stm_addr[i]), rng_state[15:0] | 16'h0001);
    end
    for (int i = 0; i < 5; i++) begin
      rng_state = xorshift32(rng_state);
      bus_write(pin_addr(autd_pkg::BRAM_SELECT_NORMAL, bad_addr[i]), rng_state[15:0]);
    end
    check_scan();
  endtask

  initial begin
    CPU_CKIO = 1'b0;
    forever #(CLK_PERIOD / 2) CPU_CKIO = ~CPU_CKIO;
  end

  initial begin
    #(2 * ALL_TESTS * CLK_PERIOD);
    fail_run("Timeout: the tests did not finish in the expected time");
  end

  initial begin
    rst        = 1'b1;
    cpu_addr   = '0;
    cpu_data   = '0;
    cpu_cs1_n  = 1'b1;
    cpu_we0_n  = 1'b1;
    rng_state  = 32'd54;
    cur_sample = '0;
    reset_walk();
    constant_modulation();
    union_decode();
    modulation_stepping();
    ignored_writes();
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== verification/autd_drive_properties.sv ====
// ====================
// Bound checks on a valid and index stream. Attached once to the drive
// memory scan and once to the combiner output.
// ====================

`timescale 1ns/1ps

module autd_drive_properties (
  input logic       CPU_CKIO,
  input logic       rst,
  input logic       valid,
  input logic [7:0] idx
);

  // Synchronous reset clears the strobe at the next edge
  valid_low_in_reset: assert property (
    @(posedge CPU_CKIO) rst |=> !valid
  ) else $error("valid is high after a reset cycle");

  // Index steps by one and wraps after the last transducer
  index_in_order: assert property (
    @(posedge CPU_CKIO) disable iff (rst)
    (valid && $past(valid)) |->
      (idx == (($past(idx) == 8'(autd_pkg::NUM_TRANS - 1)) ? 8'd0 : $past(idx) + 8'd1))
  ) else $error("index did not advance by one or wrap to zero");

  index_in_range: assert property (
    @(posedge CPU_CKIO) disable iff (rst)
    valid |-> (idx < 8'(autd_pkg::NUM_TRANS))
  ) else $error("index is past the last transducer");

endmodule

bind drive_memory autd_drive_properties u_scan_props (
  .CPU_CKIO (CPU_CKIO),
  .rst      (rst),
  .valid    (scan_valid),
  .idx      (scan_idx)
);

bind duty_combiner autd_drive_properties u_out_props (
  .CPU_CKIO (CPU_CKIO),
  .rst      (rst),
  .valid    (out_valid),
  .idx      (out_idx)
);

// ==== rtl/autd_drive_top.sv ====
// ====================
// Top level of the drive-data path. Decodes the SRAM-style CPU pins into
// the write bus and ties the modulation unit, drive memory and combiner
// into one duty and phase stream.
// ====================

`timescale 1ns/1ps

module autd_drive_top (
  input  logic        CPU_CKIO,
  input  logic        rst,
  input  logic [16:0] cpu_addr,
  input  logic [15:0] cpu_data,
  input  logic        cpu_cs1_n,
  input  logic        cpu_we0_n,
  output logic        out_valid,
  output logic [7:0]  out_idx,
  output logic [7:0]  out_duty,
  output logic [7:0]  out_phase
);

  cpu_bus_if bus ();

  logic       scan_valid;
  logic [7:0] scan_idx;
  logic [7:0] intensity;
  logic [7:0] phase;
  logic [7:0] mod_value;

  // Bit 0 of the pin address is the byte lane and is not used
  assign bus.en          = ~cpu_cs1_n;
  assign bus.we          = ~cpu_we0_n;
  assign bus.bram_select = cpu_addr[16:15];
  assign bus.bram_addr   = cpu_addr[14:1];
  assign bus.data_in     = cpu_data;

  modulation_unit u_mod (
    .CPU_CKIO  (CPU_CKIO),
    .rst       (rst),
    .bus       (bus.mem),
    .mod_value (mod_value)
  );

  drive_memory u_drive (
    .CPU_CKIO   (CPU_CKIO),
    .rst        (rst),
    .bus        (bus.mem),
    .scan_valid (scan_valid),
    .scan_idx   (scan_idx),
    .intensity  (intensity),
    .phase      (phase)
  );

  duty_combiner u_comb (
    .CPU_CKIO   (CPU_CKIO),
    .rst        (rst),
    .scan_valid (scan_valid),
    .scan_idx   (scan_idx),
    .intensity  (intensity),
    .phase      (phase),
    .mod_value  (mod_value),
    .out_valid  (out_valid),
    .out_idx    (out_idx),
    .out_duty   (out_duty),
    .out_phase  (out_phase)
  );

endmodule

// ==== rtl/duty_combiner.sv ====
// ====================
// Scales each scanned intensity by the current modulation sample and
// registers the duty, phase and index stream one cycle after scan_valid.
// ====================

`timescale 1ns/1ps

module duty_combiner (
  input  logic       CPU_CKIO,
  input  logic       rst,
  input  logic       scan_valid,
  input  logic [7:0] scan_idx,
  input  logic [7:0] intensity,
  input  logic [7:0] phase,
  input  logic [7:0] mod_value,
  output logic       out_valid,
  output logic [7:0] out_idx,
  output logic [7:0] out_duty,
  output logic [7:0] out_phase
);

  logic [15:0] product;

  assign product = intensity * mod_value;  // Full 8x8 product, upper byte is the duty

  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= scan_valid;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    out_idx   <= scan_idx;
    out_duty  <= product[15:8];
    out_phase <= phase;
  end

endmodule

// ==== rtl/drive_memory.sv ====
// ====================
// Per-transducer intensity and phase memory. Host writes land in the
// normal region; a free-running scan reads one transducer per cycle and
// presents the pair with its index one cycle later.
// ====================

`timescale 1ns/1ps

module drive_memory (
  input  logic       CPU_CKIO,
  input  logic       rst,
  cpu_bus_if.mem     bus,
  output logic       scan_valid,
  output logic [7:0] scan_idx,
  output logic [7:0] intensity,
  output logic [7:0] phase
);

  autd_pkg::bus_word_t mem [autd_pkg::NUM_TRANS];
  autd_pkg::bus_word_t rd_word;

  logic [7:0] scan_cnt;
  logic       mem_wr;

  // Addresses past the last transducer are dropped
  assign mem_wr = bus.en && bus.we &&
                  (bus.bram_select == autd_pkg::BRAM_SELECT_NORMAL) &&
                  (bus.bram_addr < autd_pkg::NUM_TRANS);

  always_ff @(posedge CPU_CKIO) begin
    if (mem_wr) begin
      mem[bus.bram_addr[7:0]] <= bus.data_in;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      scan_cnt <= '0;
    end else if (scan_cnt == 8'(autd_pkg::NUM_TRANS - 1)) begin
      scan_cnt <= '0;
    end else begin
      scan_cnt <= scan_cnt + 8'd1;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      scan_valid <= 1'b0;
      scan_idx   <= '0;
    end else begin
      scan_valid <= 1'b1;  // Runs freely once out of reset
      scan_idx   <= scan_cnt;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    rd_word <= mem[scan_cnt];
  end

  assign intensity = rd_word.drive.intensity;
  assign phase     = rd_word.drive.phase;

endmodule

// ==== rtl/modulation_unit.sv ====
// ====================
// Modulation sample memory with its cycle and divider registers.
// Steps a sample index every freq_div cycles and presents the sample at
// that index as mod_value, one cycle after the index.
// ====================

`timescale 1ns/1ps

module modulation_unit (
  input  logic       CPU_CKIO,
  input  logic       rst,
  cpu_bus_if.mem     bus,
  output logic [7:0] mod_value
);

  autd_pkg::bus_word_t mem [autd_pkg::MOD_WORDS];
  autd_pkg::bus_word_t rd_word;
  logic rd_odd;

  logic [$clog2(autd_pkg::MOD_WORDS)-1:0] mem_addr;
  logic [$clog2(autd_pkg::MOD_WORDS):0]   mod_cycle;
  logic [$clog2(autd_pkg::MOD_WORDS):0]   sample_idx;
  logic [31:0] freq_div;
  logic [31:0] div_cnt;

  logic wr;
  logic mem_wr;
  logic ctl_wr;
  logic cyc_wr;
  logic div_wr;
  logic step;

  assign wr       = bus.en && bus.we;
  assign mem_addr = bus.bram_addr[$clog2(autd_pkg::MOD_WORDS)-1:0];
  assign mem_wr   = wr && (bus.bram_select == autd_pkg::BRAM_SELECT_MOD) &&
                    (bus.bram_addr < autd_pkg::MOD_WORDS);
  assign ctl_wr   = wr && (bus.bram_select == autd_pkg::BRAM_SELECT_CONTROLLER);
  assign cyc_wr   = ctl_wr && (bus.bram_addr == autd_pkg::ADDR_MOD_CYCLE);
  assign div_wr   = ctl_wr && ((bus.bram_addr == autd_pkg::ADDR_MOD_FREQ_DIV_0) ||
                               (bus.bram_addr == autd_pkg::ADDR_MOD_FREQ_DIV_1));

  always_ff @(posedge CPU_CKIO) begin
    if (mem_wr) begin
      mem[mem_addr] <= bus.data_in;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      mod_cycle <= '0;
      freq_div  <= 32'd1;
    end else if (ctl_wr) begin
      case (bus.bram_addr)
        autd_pkg::ADDR_MOD_CYCLE:      mod_cycle <= bus.data_in[$bits(mod_cycle)-1:0];
        autd_pkg::ADDR_MOD_FREQ_DIV_0: freq_div[15:0] <= bus.data_in;
        autd_pkg::ADDR_MOD_FREQ_DIV_1: freq_div[31:16] <= bus.data_in;
        default: ;
      endcase
    end
  end

  // A divider of 0 or 1 steps every cycle
  assign step = (freq_div <= 32'd1) || (div_cnt >= freq_div - 32'd1);

  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      div_cnt    <= '0;
      sample_idx <= '0;
    end else begin
      if (div_wr || step) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 32'd1;
      end
      if (cyc_wr) begin
        sample_idx <= '0;
      end else if (step && !div_wr) begin
        sample_idx <= (sample_idx >= mod_cycle) ? '0 : sample_idx + 1'b1;
      end
    end
  end

  // Word holds two samples, the index LSB picks one
  always_ff @(posedge CPU_CKIO) begin
    rd_word <= mem[sample_idx[$clog2(autd_pkg::MOD_WORDS):1]];
    rd_odd  <= sample_idx[0];
  end

  assign mod_value = rd_odd ? rd_word.mod.sample_hi : rd_word.mod.sample_lo;

endmodule

// ==== rtl/cpu_bus_if.sv ====
// ====================
// Decoded CPU write bus. The top level drives it from the raw pins and
// the memory blocks sample it on CPU_CKIO.
// ====================

`timescale 1ns/1ps

interface cpu_bus_if;

  logic                en;           // Chip select active
  logic                we;           // Write enable active
  logic [1:0]          bram_select;
  logic [13:0]         bram_addr;
  autd_pkg::bus_word_t data_in;

  modport host (
    output en, we, bram_select, bram_addr, data_in
  );

  modport mem (
    input en, we, bram_select, bram_addr, data_in
  );

endinterface

// ==== rtl/autd_pkg.sv ====
// ====================
// Shared definitions for the drive-data path. Blocks refer to these by
// scoped name, e.g. autd_pkg::NUM_TRANS, and the bus word union gives
// the two ways a written data word is decoded.
// ====================

package autd_pkg;

  // Array geometry
  localparam int NUM_TRANS = 249;
  localparam int MOD_WORDS = 2048;  // Two 8-bit samples per word

  // Region codes in cpu_addr[16:15]
  localparam logic [1:0] BRAM_SELECT_CONTROLLER = 2'd0;
  localparam logic [1:0] BRAM_SELECT_MOD        = 2'd1;
  localparam logic [1:0] BRAM_SELECT_NORMAL     = 2'd2;
  localparam logic [1:0] BRAM_SELECT_STM        = 2'd3;

  // Controller register word addresses
  localparam logic [13:0] ADDR_MOD_CYCLE      = 14'h0020;  // Index of the last sample
  localparam logic [13:0] ADDR_MOD_FREQ_DIV_0 = 14'h0021;  // Divider bits 15:0
  localparam logic [13:0] ADDR_MOD_FREQ_DIV_1 = 14'h0022;  // Divider bits 31:16

  // One bus data word as seen by the drive memory or the modulation memory
  typedef union packed {
    struct packed {
      logic [7:0] intensity;
      logic [7:0] phase;
    } drive;
    struct packed {
      logic [7:0] sample_hi;  // Odd sample
      logic [7:0] sample_lo;  // Even sample
    } mod;
  } bus_word_t;

endpackage
